/* verilog/accum_pkg.sv */
`default_nettype none

package accum_pkg;

    // one lane per digitizer board
    localparam int LANES = 7;
    // bytes gathered into one 64-bit sample
    localparam int BYTES_PER_WORD = 8;
    // chunks making up one event, chunk number wraps after the last
    localparam int CHUNKS_PER_EVENT = 4;
    // widest buffer address carried between modules
    // each module uses only the low mem_addr_bits() of it
    localparam int MEM_ADDR_W = 16;

    typedef logic [7:0] byte_t;
    typedef logic [BYTES_PER_WORD*8-1:0] sample_t;
    // lane 0 sits in the low byte
    typedef byte_t [LANES-1:0] lane_bytes_t;
    typedef logic [2:0] lane_id_t;
    typedef logic [1:0] chunk_id_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    // tag sent with every payload word
    typedef struct packed {
        chunk_id_t chunk;
        lane_id_t lane;
    } ident_t;

    typedef struct packed {
        logic en;
        logic bank;
        mem_addr_t addr;
        sample_t data;
    } mem_wr_t;

    typedef struct packed {
        logic en;
        logic bank;
        mem_addr_t addr;
    } mem_rd_t;

    typedef struct packed {
        sample_t data;
        ident_t ident;
        logic last;
    } payload_t;

    // address bits needed for one bank of LANES x spc samples
    function automatic int mem_addr_bits(int spc);
        return $clog2(LANES * spc);
    endfunction

endpackage

`default_nettype wire

/* verilog/lane_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_fifo #(
    parameter int LANE_FIFO_DEPTH = 4
) (
    input  logic              memclk,
    input  logic              memresetn,
    input  logic              push_i,
    input  accum_pkg::byte_t  byte_i,
    output logic              not_full_o,
    output accum_pkg::sample_t sample_o,
    output logic              valid_o,
    input  logic              pop_i
);
    import accum_pkg::*;

    localparam int PTR_W = (LANE_FIFO_DEPTH > 1) ? $clog2(LANE_FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(LANE_FIFO_DEPTH + 1);
    localparam int BCNT_W = $clog2(BYTES_PER_WORD);

    // packer: bytes shift in from the top, so the first byte ends up lowest
    logic [BCNT_W-1:0] byte_cnt;
    sample_t pack_q;
    sample_t pack_next;
    logic sample_done;

    // sample storage, circular
    sample_t mem [LANE_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign pack_next = {byte_i, pack_q[$bits(sample_t)-1:8]};
    // last byte of a sample arriving now
    assign sample_done = push_i && (byte_cnt == BCNT_W'(BYTES_PER_WORD - 1));

    always_ff @(posedge memclk) begin
        if (push_i) begin
            pack_q <= pack_next;
        end
        if (sample_done) begin
            mem[wr_ptr] <= pack_next;
        end
    end

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            byte_cnt <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push_i) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
            if (sample_done) begin
                wr_ptr <= (wr_ptr == PTR_W'(LANE_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(LANE_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({sample_done, pop_i})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the sample being packed takes the next free slot once complete
    assign not_full_o = (count < CNT_W'(LANE_FIFO_DEPTH));
    assign valid_o = (count != '0);
    assign sample_o = mem[rd_ptr];

    // writer only pops lanes it saw valid in its check cycle
    a_no_pop_empty: assert property (@(posedge memclk) disable iff (!memresetn)
        pop_i |-> valid_o);

endmodule

`default_nettype wire

/* verilog/chunk_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module chunk_writer #(
    parameter int SAMPLES_PER_CHUNK = 8
) (
    input  logic                                        memclk,
    input  logic                                        memresetn,
    input  accum_pkg::sample_t [accum_pkg::LANES-1:0]   lane_sample_i,
    input  logic [accum_pkg::LANES-1:0]                 lane_valid_i,
    output logic [accum_pkg::LANES-1:0]                 lane_pop_o,
    input  logic [1:0]                                  bank_full_i,
    output accum_pkg::mem_wr_t                          mem_wr_o,
    output logic                                        chunk_done_o,
    output accum_pkg::chunk_id_t                        chunk_id_o
);
    import accum_pkg::*;

    localparam int SAMPLE_W = $clog2(SAMPLES_PER_CHUNK);

    // idle waits for the first data of an event, bank wait for a free bank
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CHECK,
        ST_WRITE,
        ST_BANK_WAIT
    } state_t;

    state_t state;
    lane_id_t lane_q;
    logic [SAMPLE_W-1:0] sample_q;
    chunk_id_t chunk_q;
    logic bank;
    logic last_lane;
    logic last_sample;

    // low bit of the chunk number picks the bank
    assign bank = chunk_q[0];
    assign last_lane = (lane_q == lane_id_t'(LANES - 1));
    assign last_sample = (sample_q == SAMPLE_W'(SAMPLES_PER_CHUNK - 1));

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            state <= ST_IDLE;
            lane_q <= '0;
            sample_q <= '0;
            chunk_q <= '0;
            chunk_done_o <= 1'b0;
            chunk_id_o <= '0;
        end else begin
            chunk_done_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (lane_valid_i[0] && !bank_full_i[bank]) begin
                        state <= ST_CHECK;
                    end
                end
                // a round starts only with a sample waiting on every lane
                ST_CHECK: begin
                    if (&lane_valid_i) begin
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (last_lane) begin
                        lane_q <= '0;
                        if (last_sample) begin
                            sample_q <= '0;
                            chunk_done_o <= 1'b1;
                            chunk_id_o <= chunk_q;
                            // flip to the other bank, event end goes back to idle
                            if (chunk_q == chunk_id_t'(CHUNKS_PER_EVENT - 1)) begin
                                chunk_q <= '0;
                                state <= ST_IDLE;
                            end else begin
                                chunk_q <= chunk_q + 1'b1;
                                state <= ST_BANK_WAIT;
                            end
                        end else begin
                            sample_q <= sample_q + 1'b1;
                            state <= ST_CHECK;
                        end
                    end else begin
                        lane_q <= lane_q + 1'b1;
                    end
                end
                ST_BANK_WAIT: begin
                    if (!bank_full_i[bank]) begin
                        state <= ST_CHECK;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_comb begin
        mem_wr_o.en = (state == ST_WRITE);
        mem_wr_o.bank = bank;
        // lane * SAMPLES_PER_CHUNK + sample, a plain concat for power-of-two sizes
        mem_wr_o.addr = mem_addr_t'({lane_q, sample_q});
        mem_wr_o.data = lane_sample_i[lane_q];
        // pop the lane in its own write cycle
        for (int l = 0; l < LANES; l++) begin
            lane_pop_o[l] = (state == ST_WRITE) && (lane_q == lane_id_t'(l));
        end
    end

    // bank flag is set by the buffer and cleared by the reader
    a_no_write_full_bank: assert property (@(posedge memclk) disable iff (!memresetn)
        mem_wr_o.en |-> !bank_full_i[mem_wr_o.bank]);

endmodule

`default_nettype wire

/* verilog/chunk_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module chunk_buffer #(
    parameter int SAMPLES_PER_CHUNK = 8
) (
    input  logic               memclk,
    input  logic               memresetn,
    input  accum_pkg::mem_wr_t mem_wr_i,
    input  accum_pkg::mem_rd_t mem_rd_i,
    output accum_pkg::sample_t rd_data_o,
    input  logic               fill_i,
    input  logic               fill_bank_i,
    input  logic               release_i,
    input  logic               release_bank_i,
    output logic [1:0]         bank_full_o
);
    import accum_pkg::*;

    localparam int ADDR_W = mem_addr_bits(SAMPLES_PER_CHUNK);
    localparam int BANK_DEPTH = LANES * SAMPLES_PER_CHUNK;

    // two banks, one chunk each
    sample_t mem [2][BANK_DEPTH];
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;

    assign wr_addr = mem_wr_i.addr[ADDR_W-1:0];
    assign rd_addr = mem_rd_i.addr[ADDR_W-1:0];

    // write port, and read port with one registered stage
    always_ff @(posedge memclk) begin
        if (mem_wr_i.en) begin
            mem[mem_wr_i.bank][wr_addr] <= mem_wr_i.data;
        end
        if (mem_rd_i.en) begin
            rd_data_o <= mem[mem_rd_i.bank][rd_addr];
        end
    end

    // full flags, set when the writer closes a chunk, cleared on readout
    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            bank_full_o <= 2'b00;
        end else begin
            for (int b = 0; b < 2; b++) begin
                if (release_i && (release_bank_i == 1'(b))) begin
                    bank_full_o[b] <= 1'b0;
                end else if (fill_i && (fill_bank_i == 1'(b))) begin
                    bank_full_o[b] <= 1'b1;
                end
            end
        end
    end

    // writer must have waited for the bank to drain
    a_no_fill_full: assert property (@(posedge memclk) disable iff (!memresetn)
        fill_i |-> !bank_full_o[fill_bank_i]);

endmodule

`default_nettype wire

/* verilog/chunk_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module chunk_reader #(
    parameter int SAMPLES_PER_CHUNK = 8
) (
    input  logic                 memclk,
    input  logic                 memresetn,
    input  logic                 chunk_done_i,
    input  accum_pkg::chunk_id_t chunk_id_i,
    input  logic                 has_space_i,
    output accum_pkg::mem_rd_t   mem_rd_o,
    input  accum_pkg::sample_t   rd_data_i,
    output logic                 release_o,
    output logic                 release_bank_o,
    output accum_pkg::payload_t  payload_o,
    output logic                 payload_valid_o
);
    import accum_pkg::*;

    localparam int SAMPLE_W = $clog2(SAMPLES_PER_CHUNK);

    // queue of finished chunks, never more than the two banks hold
    chunk_id_t q_mem [2];
    logic q_wr_ptr;
    logic q_rd_ptr;
    logic [1:0] q_count;
    logic q_full;
    logic start;

    // read sequencer
    logic busy;
    chunk_id_t cur_chunk;
    lane_id_t lane_cnt;
    logic [SAMPLE_W-1:0] samp_cnt;
    logic last_samp;
    logic last_read;

    // tag and last flag, one cycle behind the read enable like the data
    ident_t ident_q;
    logic last_q;

    assign q_full = (q_count == 2'd2);
    // consumer space is only looked at here
    assign start = (q_count != 2'd0) && !busy && has_space_i;
    assign last_samp = (samp_cnt == SAMPLE_W'(SAMPLES_PER_CHUNK - 1));
    assign last_read = busy && last_samp && (lane_cnt == lane_id_t'(LANES - 1));

    always_ff @(posedge memclk) begin
        if (chunk_done_i) begin
            q_mem[q_wr_ptr] <= chunk_id_i;
        end
        ident_q <= '{chunk: cur_chunk, lane: lane_cnt};
        last_q <= last_samp;
    end

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            q_wr_ptr <= 1'b0;
            q_rd_ptr <= 1'b0;
            q_count <= 2'd0;
            busy <= 1'b0;
            cur_chunk <= '0;
            lane_cnt <= '0;
            samp_cnt <= '0;
            payload_valid_o <= 1'b0;
        end else begin
            if (chunk_done_i) begin
                q_wr_ptr <= ~q_wr_ptr;
            end
            if (start) begin
                q_rd_ptr <= ~q_rd_ptr;
            end
            case ({chunk_done_i, start})
                2'b10: q_count <= q_count + 1'b1;
                2'b01: q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
            if (start) begin
                busy <= 1'b1;
                cur_chunk <= q_mem[q_rd_ptr];
                lane_cnt <= '0;
                samp_cnt <= '0;
            end else if (busy) begin
                // linear addresses, samples within a lane then next lane
                samp_cnt <= samp_cnt + 1'b1;
                if (last_samp) begin
                    lane_cnt <= lane_cnt + 1'b1;
                end
                // leaves one idle cycle before the next start
                if (last_read) begin
                    busy <= 1'b0;
                end
            end
            payload_valid_o <= busy;
        end
    end

    always_comb begin
        mem_rd_o.en = busy;
        mem_rd_o.bank = cur_chunk[0];
        mem_rd_o.addr = mem_addr_t'({lane_cnt, samp_cnt});
    end

    // bank is free once its last sample has been read
    assign release_o = last_read;
    assign release_bank_o = cur_chunk[0];

    assign payload_o = '{data: rd_data_i, ident: ident_q, last: last_q};

    // a full queue means both banks are full, so the writer cannot close a chunk
    a_no_push_full: assert property (@(posedge memclk) disable iff (!memresetn)
        chunk_done_i |-> !q_full);

endmodule

`default_nettype wire

/* verilog/event_accumulator.sv */
`timescale 1ns/1ps
`default_nettype none

module event_accumulator #(
    parameter int SAMPLES_PER_CHUNK = 8,
    parameter int LANE_FIFO_DEPTH = 4
) (
    input  logic                   memclk,
    input  logic                   memresetn,
    input  logic                   in_valid_i,
    input  accum_pkg::lane_bytes_t in_data_i,
    output logic                   in_ready_o,
    input  logic                   has_space_i,
    output accum_pkg::payload_t    payload_o,
    output logic                   payload_valid_o
);
    import accum_pkg::*;

    logic [LANES-1:0] lane_not_full;
    logic [LANES-1:0] lane_valid;
    logic [LANES-1:0] lane_pop;
    sample_t [LANES-1:0] lane_sample;
    logic beat_push;

    logic [1:0] bank_full;
    mem_wr_t mem_wr;
    mem_rd_t mem_rd;
    sample_t rd_data;
    logic chunk_done;
    chunk_id_t chunk_id;
    logic bank_release;
    logic release_bank;

    // all lanes take the beat together, so any full lane holds the input
    assign in_ready_o = &lane_not_full;
    assign beat_push = in_valid_i && in_ready_o;

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        lane_fifo #(
            .LANE_FIFO_DEPTH(LANE_FIFO_DEPTH)
        ) u_lane_fifo (
            .memclk(memclk),
            .memresetn(memresetn),
            .push_i(beat_push),
            .byte_i(in_data_i[l]),
            .not_full_o(lane_not_full[l]),
            .sample_o(lane_sample[l]),
            .valid_o(lane_valid[l]),
            .pop_i(lane_pop[l])
        );
    end

    chunk_writer #(
        .SAMPLES_PER_CHUNK(SAMPLES_PER_CHUNK)
    ) u_chunk_writer (
        .memclk(memclk),
        .memresetn(memresetn),
        .lane_sample_i(lane_sample),
        .lane_valid_i(lane_valid),
        .lane_pop_o(lane_pop),
        .bank_full_i(bank_full),
        .mem_wr_o(mem_wr),
        .chunk_done_o(chunk_done),
        .chunk_id_o(chunk_id)
    );

    // the finished chunk's bank is the low bit of its number
    chunk_buffer #(
        .SAMPLES_PER_CHUNK(SAMPLES_PER_CHUNK)
    ) u_chunk_buffer (
        .memclk(memclk),
        .memresetn(memresetn),
        .mem_wr_i(mem_wr),
        .mem_rd_i(mem_rd),
        .rd_data_o(rd_data),
        .fill_i(chunk_done),
        .fill_bank_i(chunk_id[0]),
        .release_i(bank_release),
        .release_bank_i(release_bank),
        .bank_full_o(bank_full)
    );

    chunk_reader #(
        .SAMPLES_PER_CHUNK(SAMPLES_PER_CHUNK)
    ) u_chunk_reader (
        .memclk(memclk),
        .memresetn(memresetn),
        .chunk_done_i(chunk_done),
        .chunk_id_i(chunk_id),
        .has_space_i(has_space_i),
        .mem_rd_o(mem_rd),
        .rd_data_i(rd_data),
        .release_o(bank_release),
        .release_bank_o(release_bank),
        .payload_o(payload_o),
        .payload_valid_o(payload_valid_o)
    );

endmodule

`default_nettype wire

/* tb/tb_event_accumulator.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_event_accumulator;
    import accum_pkg::*;

    localparam int SPC = 8;
    localparam int FIFO_DEPTH = 4;
    // beats and output words in one event
    localparam int EVENT_BEATS = CHUNKS_PER_EVENT * SPC * BYTES_PER_WORD;
    localparam int EVENT_WORDS = CHUNKS_PER_EVENT * LANES * SPC;
    // tests 2 to 4 send one event each and test 5 sends three
    localparam int TOTAL_EVENTS = 6;
    localparam int TOTAL_WORDS = TOTAL_EVENTS * EVENT_WORDS;
    localparam int WATCHDOG_CYCLES = TOTAL_EVENTS * EVENT_BEATS * 20 + 2000;

    logic memclk;
    logic memresetn;
    logic in_valid_i;
    lane_bytes_t in_data_i;
    logic in_ready_o;
    logic has_space_i;
    payload_t payload_o;
    logic payload_valid_o;

    // every accepted beat in arrival order
    lane_bytes_t beat_log[$];
    logic [31:0] lfsr_state;
    // high while the consumer is held off
    logic hold_output;
    int words_seen;
    int target;

    event_accumulator #(
        .SAMPLES_PER_CHUNK(SPC),
        .LANE_FIFO_DEPTH(FIFO_DEPTH)
    ) u_event_accumulator (
        .memclk(memclk),
        .memresetn(memresetn),
        .in_valid_i(in_valid_i),
        .in_data_i(in_data_i),
        .in_ready_o(in_ready_o),
        .has_space_i(has_space_i),
        .payload_o(payload_o),
        .payload_valid_o(payload_valid_o)
    );

    initial begin
        memclk = 1'b0;
        forever #10 memclk = ~memclk;
    end

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] bits;
        logic fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits = {bits[62:0], fb};
        end
        return bits;
    endfunction

    // expected word n of the whole run in chunk then lane then sample order
    function automatic payload_t expected_word(input int n);
        int chunk_idx;
        int rem;
        int lane;
        int samp;
        int first_beat;
        lane_bytes_t beat;
        payload_t p;
        chunk_idx = n / (LANES * SPC);
        rem = n % (LANES * SPC);
        lane = rem / SPC;
        samp = rem % SPC;
        // eight beats per sample with the first byte lowest
        first_beat = (chunk_idx * SPC + samp) * BYTES_PER_WORD;
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            beat = beat_log[first_beat + b];
            p.data[b*8 +: 8] = beat[lane];
        end
        p.ident.chunk = chunk_id_t'(chunk_idx % CHUNKS_PER_EVENT);
        p.ident.lane = lane_id_t'(lane);
        p.last = (samp == SPC - 1);
        return p;
    endfunction

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_ident(input string name, input ident_t got, input ident_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_last(input string name, input bit got, input bit exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // sends n beats with optional random idle cycles between them
    task automatic send_beats(input int n, input bit gaps);
        int sent;
        logic [63:0] r;
        bit skip;
        sent = 0;
        while (sent < n) begin
            @(posedge memclk);
            if (in_valid_i && in_ready_o) begin
                sent++;
            end
            // a held beat stays until taken
            if (!in_valid_i || in_ready_o) begin
                skip = 1'b0;
                if (gaps) begin
                    r = take_bits(1);
                    skip = r[0];
                end
                if (sent < n && !skip) begin
                    r = take_bits(56);
                    in_valid_i <= 1'b1;
                    in_data_i <= r[55:0];
                end else begin
                    in_valid_i <= 1'b0;
                end
            end
        end
    endtask

    task automatic wait_words(input int n);
        while (words_seen < n) begin
            @(posedge memclk);
        end
    endtask

    // record the beats as the DUT takes them
    always @(posedge memclk) begin
        if (memresetn && in_valid_i && in_ready_o) begin
            beat_log.push_back(in_data_i);
        end
    end

    always @(posedge memclk) begin : compare_words
        payload_t exp;
        int need;
        if (memresetn && payload_valid_o) begin
            if (hold_output) begin
                $display("ERROR: payload word appeared while has_space_i was low");
                abort_run();
            end
            // last beat this word draws on
            need = ((words_seen / (LANES * SPC)) * SPC + words_seen % SPC + 1) * BYTES_PER_WORD;
            if (beat_log.size() < need) begin
                $display("ERROR: payload word %0d arrived before its input bytes", words_seen);
                abort_run();
            end
            exp = expected_word(words_seen);
            check_sample("payload_o.data", payload_o.data, exp.data);
            check_ident("payload_o.ident", payload_o.ident, exp.ident);
            check_last("payload_o.last", payload_o.last, exp.last);
            words_seen++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge memclk);
        $display("ERROR: payload stalled, %0d of %0d words after %0d cycles",
                 words_seen, TOTAL_WORDS, WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin
        lfsr_state = 32'hbd8aaf5b;
        memresetn <= 1'b0;
        in_valid_i <= 1'b0;
        in_data_i <= '0;
        has_space_i <= 1'b1;
        hold_output <= 1'b0;
        words_seen = 0;
        repeat (3) @(posedge memclk);
        memresetn <= 1'b1;

        // test 1 checks idle outputs right after reset
        @(posedge memclk);
        check_flag("payload_valid_o", payload_valid_o, 1'b0);
        check_flag("in_ready_o", in_ready_o, 1'b1);

        // test 2 sends one event with steady input
        target = EVENT_WORDS;
        send_beats(EVENT_BEATS, 1'b0);
        wait_words(target);

        // test 3 repeats it with gaps on the input
        target += EVENT_WORDS;
        send_beats(EVENT_BEATS, 1'b1);
        wait_words(target);

        // test 4 blocks the consumer until the input stalls
        @(posedge memclk);
        has_space_i <= 1'b0;
        hold_output <= 1'b1;
        target += EVENT_WORDS;
        fork
            send_beats(EVENT_BEATS, 1'b0);
            begin : stall_then_open
                int cycles;
                cycles = 0;
                while (in_ready_o) begin
                    @(posedge memclk);
                    cycles++;
                    if (cycles > 4 * EVENT_BEATS) begin
                        $display("ERROR: in_ready_o never fell while the output was blocked");
                        abort_run();
                    end
                end
                // stay stalled a while with nothing coming out
                repeat (50) @(posedge memclk);
                has_space_i <= 1'b1;
                hold_output <= 1'b0;
            end
        join
        wait_words(target);

        // test 5 sends three events with random consumer space each cycle
        target += 3 * EVENT_WORDS;
        fork
            send_beats(3 * EVENT_BEATS, 1'b1);
            begin : random_space
                logic [63:0] r;
                while (words_seen < target) begin
                    @(posedge memclk);
                    r = take_bits(1);
                    has_space_i <= r[0];
                end
                has_space_i <= 1'b1;
            end
        join

        // quiet tail where a stray extra word still reaches the compare process
        repeat (100) @(posedge memclk);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
verilog/accum_pkg.sv
verilog/lane_fifo.sv
verilog/chunk_writer.sv
verilog/chunk_buffer.sv
verilog/chunk_reader.sv
verilog/event_accumulator.sv
tb/tb_event_accumulator.sv

/* Makefile */
SRCS := $(shell cat tb.f)
BIN := obj_dir/Vtb_event_accumulator

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) tb.f
	verilator --binary --timing --assert --top-module tb_event_accumulator \
		-Mdir obj_dir -o Vtb_event_accumulator -f tb.f

# pass only if the pass line shows up in the output
run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -qx 'Test OK'

clean:
	rm -rf obj_dir
